/* hw/oramGeomPkg.sv */
//==========================================================================
// ORAM tree geometry
// sizes of the Path ORAM tree, its subtree layout and the index widths
// shared by the head generator and the burst issuer
//==========================================================================
`default_nettype none

package oramGeomPkg;

	// tree shape
	localparam int oramL = 9;     // leaf label bits, the tree has oramL+1 levels
	localparam int levelW = 4;    // enough to count levels 0 to oramL

	// subtree layout, each subtree of lSt levels sits in one contiguous slot
	localparam int lSt = 3;
	localparam int numSt = 4;     // subtree layers from root to leaves
	localparam int lStBottom = (oramL + 1) % lSt; // height of the short bottom layer

	// number of full subtrees above the bottom layer
	// layer k holds 2^(lSt*k) subtrees, so this is 1 + 8 + 64 for the default shape
	function automatic int tallCount();
		int n;
		n = 0;
		for (int k = 0; k < numSt - 1; k++) begin
			n += 1 << (lSt * k);
		end
		return n;
	endfunction

	localparam int numTallSt = tallCount();

	// the highest slot base lands in the bottom layer and needs 11 bits
	localparam int bktIdxW = 11;
	// heap index over the tree of subtrees, the deepest one is 584
	localparam int stIdxW = 10;

	typedef logic [oramL-1:0] leafT;     // lsb picks the branch at the root
	typedef logic [bktIdxW-1:0] bktIdxT; // bucket position after the layout
	typedef logic [levelW-1:0] levelT;   // 0 is the root

endpackage

`default_nettype wire

/* hw/dramMapPkg.sv */
//==========================================================================
// DRAM burst map
// how many bursts make up a bucket and where the tree starts in the
// burst address space
//==========================================================================
`default_nettype none

package dramMapPkg;

	// a bucket is read or written as a fixed run of bursts
	localparam int burstsPerBkt = 4;
	localparam int burstLog = $clog2(burstsPerBkt); // burst counter width

	// addresses count bursts, not bytes
	localparam int dramAddrW = 16;

	typedef logic [dramAddrW-1:0] dramAddrT;

	// first burst of bucket 0
	// everything below this is left to other users of the memory
	localparam dramAddrT dramBase = 16'h0400;

endpackage

`default_nettype wire

/* hw/pathAddrIf.sv */
//==========================================================================
// bucket head bus
// one laid-out bucket index per transfer, from head generator to issuer
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

interface pathAddrIf;

	logic valid;                  // head on the bus is meaningful
	logic ready;                  // issuer has room for a head
	oramGeomPkg::levelT level;    // tree level of this bucket, root is 0
	oramGeomPkg::bktIdxT bktIdx;  // bucket index after the subtree layout
	logic lastBkt;                // leaf bucket, the path ends here

	// the generator side, payload holds while valid waits for ready
	modport src (
		output valid, level, bktIdx, lastBkt,
		input ready
	);

	// the issuer side, a transfer is any edge with valid and ready high
	modport sink (
		input valid, level, bktIdx, lastBkt,
		output ready
	);

endinterface

`default_nettype wire

/* hw/pathGen.sv */
//==========================================================================
// heap path walker
// follows one root to leaf path through a complete tree of 2^arityLog
// children per node, one step per call
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pathGen #(
	parameter int arityLog = 1, // bits consumed per step, 1 walks a binary tree
	parameter int idxW = 8      // wide enough for the deepest index reached
) (
	input wire Clock,
	input wire rstN,
	input wire restart,                 // jump back to the root
	input wire step,                    // descend one level
	input wire [arityLog-1:0] pathBits, // which child to take
	output logic [idxW-1:0] idx         // heap index of the current node
);

	// heap numbering puts the children of node n at n*2^a+1 .. n*2^a+2^a
	logic [idxW-1:0] childIdx;

	assign childIdx = (idx << arityLog) + idxW'(1) + idxW'(pathBits); // first child plus offset

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			idx <= '0;
		end else if (restart) begin
			idx <= '0; // restart wins over step when both are seen
		end else if (step) begin
			idx <= childIdx;
		end
	end

	// a step that would leave the tree is the caller's job to avoid
	// the walker itself never saturates and simply wraps in idxW bits

endmodule

`default_nettype wire

/* hw/bktHeadGen.sv */
//==========================================================================
// bucket head generator
// takes a leaf label over a four-phase handshake and emits the laid-out
// bucket index of every level on the path, root first
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module bktHeadGen (
	input wire Clock,
	input wire rstN,
	input wire leafReq,
	input wire oramGeomPkg::leafT leaf,
	output logic leafAck,
	pathAddrIf.src hd
);

	import oramGeomPkg::*;

	typedef enum logic [1:0] {
		sIdle,  // waiting for a leaf
		sPrime, // walkers are at the root, head goes out next cycle
		sWalk   // heads on the bus, one level per transfer
	} stateT;

	stateT state;
	levelT level;        // level of the head on the bus
	levelT lvlInSt;      // level inside the current subtree
	leafT leafSh;        // remaining leaf bits, lsb is the next branch
	logic [lSt-2:0] stBits; // branch bits already taken inside this subtree
	logic [lSt-1:0] nextStBits;
	logic [stIdxW-1:0] stIdx;
	logic [lSt-1:0] bktInSt;
	logic accept, xfer, switchSt, shortSt;
	logic bktStep, stStep, bktRestart;
	bktIdxT slotBase;

	assign accept = (state == sIdle) && leafReq && !leafAck; // four-phase cycle fully closed
	assign xfer = hd.valid && hd.ready;
	assign switchSt = (lvlInSt == levelT'(lSt - 1)); // bottom row of a full subtree

	// first branch taken sits in the msb, so the bits read as a child number
	assign nextStBits = {stBits, leafSh[0]};

	// moving down stays inside the subtree unless we sit on its bottom row
	assign bktStep = xfer && !hd.lastBkt && !switchSt;
	assign stStep = xfer && !hd.lastBkt && switchSt;
	assign bktRestart = accept || stStep; // every new subtree starts at its own root

	// walks the tree of subtrees, one step per full subtree left behind
	pathGen #(.arityLog(lSt), .idxW(stIdxW)) stWalk (
		.Clock(Clock),
		.rstN(rstN),
		.restart(accept),
		.step(stStep),
		.pathBits(nextStBits),
		.idx(stIdx)
	);

	// walks the buckets of the current subtree
	pathGen #(.arityLog(1), .idxW(lSt)) bktWalk (
		.Clock(Clock),
		.rstN(rstN),
		.restart(bktRestart),
		.step(bktStep),
		.pathBits(leafSh[0]),
		.idx(bktInSt)
	);

	//==========================================================================
	// slot layout
	//==========================================================================

	// the bottom layer exists only when the tree height is not a multiple of lSt
	assign shortSt = (lStBottom != 0) && (level >= levelT'((numSt - 1) * lSt));

	// full subtrees get 2^lSt slots each, the short ones pack after them
	always_comb begin
		if (shortSt) begin
			slotBase = bktIdxT'(numTallSt << lSt) +
				((bktIdxT'(stIdx) - bktIdxT'(numTallSt)) << lStBottom);
		end else begin
			slotBase = bktIdxT'(stIdx) << lSt;
		end
	end

	assign hd.valid = (state == sWalk);
	assign hd.level = level;
	assign hd.bktIdx = slotBase + bktIdxT'(bktInSt);
	assign hd.lastBkt = (level == levelT'(oramL)); // the leaf bucket closes the path

	//==========================================================================
	// control
	//==========================================================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= sIdle;
			leafAck <= 1'b0;
			level <= '0;
			lvlInSt <= '0;
		end else begin
			if (accept) begin
				leafAck <= 1'b1;
			end else if (!leafReq) begin
				leafAck <= 1'b0; // requester let go, close the handshake
			end
			case (state)
				sIdle: begin
					if (accept) begin
						state <= sPrime;
						level <= '0;
						lvlInSt <= '0;
					end
				end
				sPrime: state <= sWalk;
				sWalk: begin
					if (xfer) begin
						if (hd.lastBkt) begin
							state <= sIdle; // whole path handed over
						end else begin
							level <= level + 1'b1;
							lvlInSt <= switchSt ? '0 : lvlInSt + 1'b1;
						end
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// leaf bits are consumed lsb first, one per level
	always_ff @(posedge Clock) begin
		if (accept) begin
			leafSh <= leaf;
		end else if (xfer) begin
			leafSh <= leafSh >> 1;
			stBits <= nextStBits[lSt-2:0];
		end
	end

endmodule

`default_nettype wire

/* hw/burstIssue.sv */
//==========================================================================
// burst issuer
// holds one bucket head and sends its bursts one by one over the
// four-phase command port, flagging the last burst of a path
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module burstIssue (
	input wire Clock,
	input wire rstN,
	pathAddrIf.sink hd,
	output logic cmdReq,
	output dramMapPkg::dramAddrT cmdAddr,
	output logic cmdLast,
	input wire cmdAck
);

	import oramGeomPkg::*;
	import dramMapPkg::*;

	typedef enum logic [1:0] {
		sEmpty,  // no head in hand, ready for the next one
		sLoad,   // burst address known, request goes up on this edge
		sReq,    // request up, waiting for the acknowledge
		sAckLow  // request down, waiting for the acknowledge to fall
	} stateT;

	stateT state;
	bktIdxT holdIdx;           // bucket of the head in hand
	logic holdLast;            // that head is the leaf bucket
	logic [burstLog-1:0] cnt;  // burst within the bucket
	logic take, lastBurst;
	dramAddrT burstAddr;

	assign hd.ready = (state == sEmpty); // one head at a time
	assign take = hd.valid && (state == sEmpty);
	assign lastBurst = (cnt == burstLog'(burstsPerBkt - 1));

	// buckets sit back to back, each burstsPerBkt bursts long
	assign burstAddr = dramBase + (dramAddrT'(holdIdx) << burstLog) + dramAddrT'(cnt);

	//==========================================================================
	// command handshake
	//==========================================================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= sEmpty;
			cmdReq <= 1'b0;
			cmdLast <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				sEmpty: begin
					if (take) begin
						state <= sLoad;
						cnt <= '0;
					end
				end
				sLoad: begin
					cmdReq <= 1'b1; // address goes out on the same edge
					cmdLast <= holdLast && lastBurst;
					state <= sReq;
				end
				sReq: begin
					if (cmdAck) begin
						cmdReq <= 1'b0;
						cmdLast <= 1'b0;
						state <= sAckLow;
					end
				end
				sAckLow: begin
					// a new request may only rise once the acknowledge is gone
					if (!cmdAck) begin
						if (lastBurst) begin
							state <= sEmpty;
						end else begin
							cnt <= cnt + 1'b1;
							state <= sLoad;
						end
					end
				end
				default: state <= sEmpty;
			endcase
		end
	end

	// head and address registers only move when the handshake allows it
	always_ff @(posedge Clock) begin
		if (take) begin
			holdIdx <= hd.bktIdx;
			holdLast <= hd.lastBkt;
		end
		if (state == sLoad) begin
			cmdAddr <= burstAddr; // frozen until the next sLoad, so stable under cmdReq
		end
	end

endmodule

`default_nettype wire

/* hw/oramPathAddr.sv */
//==========================================================================
// ORAM path address generator
// turns a leaf label into the DRAM burst addresses of its whole path
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module oramPathAddr (
	input wire Clock,
	input wire rstN,

	// leaf side, four-phase
	input wire leafReq,
	input wire oramGeomPkg::leafT leaf,
	output logic leafAck,

	// command side, four-phase, one burst per cycle of the handshake
	output logic cmdReq,
	output dramMapPkg::dramAddrT cmdAddr,
	output logic cmdLast, // final burst of the path
	input wire cmdAck
);

	// heads flow from the walker to the issuer, so the next walk can
	// start while the previous path is still draining
	pathAddrIf hdBus ();

	bktHeadGen u_headGen (
		.Clock(Clock),
		.rstN(rstN),
		.leafReq(leafReq),
		.leaf(leaf),
		.leafAck(leafAck),
		.hd(hdBus.src)
	);

	// a slow cmdAck stalls this one, which then holds back the walker
	burstIssue u_burst (
		.Clock(Clock),
		.rstN(rstN),
		.hd(hdBus.sink),
		.cmdReq(cmdReq),
		.cmdAddr(cmdAddr),
		.cmdLast(cmdLast),
		.cmdAck(cmdAck)
	);

endmodule

`default_nettype wire

/* dv/tbClock.sv */
//==========================================================================
// testbench clock and reset
// 40 ns clock, reset held low for the first three rising edges
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic Clock,
	output logic rstN
);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock; // 40 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge Clock);
		rstN <= 1'b1; // released on the edge, like the rest of the stimulus
	end

endmodule

`default_nettype wire

/* dv/pathChecker.sv */
//==========================================================================
// command port checker
// compares every burst on the command port with the queued expectations
// and keeps the per-test and overall counts
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pathChecker (
	input wire Clock,
	input wire rstN,
	input wire cmdReq,
	input wire dramMapPkg::dramAddrT cmdAddr,
	input wire cmdLast
);

	import oramGeomPkg::*;
	import dramMapPkg::*;

	localparam int pathLen = (oramL + 1) * burstsPerBkt;

	typedef logic [pathLen-1:0][dramAddrW-1:0] addrListT;

	dramAddrT expAddrQ[$]; // expected bursts, oldest path first
	logic expLastQ[$];     // matching cmdLast for each burst
	logic prevReq;
	int errCount = 0;
	int cmdCount = 0;
	int pathCount = 0;
	int testCount = 0;
	int errMark = 0;
	int cmdMark = 0;

	// one whole path goes in at once, only its final burst carries cmdLast
	task automatic expectPath(input addrListT addrs);
		for (int i = 0; i < pathLen; i++) begin
			expAddrQ.push_back(addrs[i]);
			expLastQ.push_back(i == pathLen - 1);
		end
	endtask

	function automatic int pending();
		return expAddrQ.size();
	endfunction

	task automatic reportError(input string what);
		$display("[%0t] %s", $time, what);
		errCount++;
	endtask

	task automatic checkCommand();
		dramAddrT expAddr;
		logic expLast;
		if (expAddrQ.size() == 0) begin
			reportError($sformatf("unexpected command to %h with no path outstanding", cmdAddr));
		end else begin
			expAddr = expAddrQ.pop_front();
			expLast = expLastQ.pop_front();
			cmdCount++;
			if (cmdAddr !== expAddr) begin
				$display("Mismatch at %0t: cmdAddr is %h, expected %h", $time, cmdAddr, expAddr);
				errCount++;
			end
			if (cmdLast !== expLast && expLast) begin
				reportError("cmdLast missing on the final burst of a path");
			end else if (cmdLast !== expLast) begin
				reportError("cmdLast raised on a burst that does not end a path");
			end
			if (expLast) begin
				pathCount++;
			end
		end
	endtask

	// addr and last are already stable in the cycle req is first seen high
	always @(posedge Clock) begin
		if (!rstN) begin
			prevReq <= 1'b0;
		end else begin
			prevReq <= cmdReq;
			if (cmdReq && !prevReq) begin
				checkCommand();
			end
		end
	end

	task automatic finishTest(input string name);
		testCount++;
		$display("test %0d, %s: %0d commands, %0d errors", testCount, name,
			cmdCount - cmdMark, errCount - errMark);
		cmdMark = cmdCount;
		errMark = errCount;
	endtask

	task automatic closeReport();
		$display("tests %0d, paths %0d, commands %0d, errors %0d", testCount, pathCount,
			cmdCount, errCount);
	endtask

endmodule

`default_nettype wire

/* dv/pathAddr_properties.sv */
//==========================================================================
// handshake properties
// four-phase rules on the leaf and command ports, bound to the top level
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pathAddrProps (
	input wire Clock,
	input wire rstN,
	input wire leafReq,
	input wire leafAck,
	input wire cmdReq,
	input wire dramMapPkg::dramAddrT cmdAddr,
	input wire cmdLast,
	input wire cmdAck
);

	int propFails = 0; // read by the testbench at the end of the run

	reqHold: assert property (@(posedge Clock) disable iff (!rstN)
		cmdReq && !cmdAck |=> cmdReq)
	else begin
		$error("cmdReq dropped before cmdAck was seen");
		propFails++;
	end

	// the issuer clears cmdLast on the same edge as cmdReq
	cmdStable: assert property (@(posedge Clock) disable iff (!rstN)
		cmdReq && $past(cmdReq) |-> $stable(cmdAddr) && $stable(cmdLast))
	else begin
		$error("command payload changed while cmdReq was high");
		propFails++;
	end

	ackNoReq: assert property (@(posedge Clock) disable iff (!rstN)
		!leafReq && !leafAck |=> !leafAck)
	else begin
		$error("leafAck rose while leafReq was low");
		propFails++;
	end

	resetQuiet: assert property (@(posedge Clock) !rstN |=> !cmdReq && !leafAck)
	else begin
		$error("cmdReq or leafAck high right after reset");
		propFails++;
	end

endmodule

bind oramPathAddr pathAddrProps u_props (
	.Clock(Clock),
	.rstN(rstN),
	.leafReq(leafReq),
	.leafAck(leafAck),
	.cmdReq(cmdReq),
	.cmdAddr(cmdAddr),
	.cmdLast(cmdLast),
	.cmdAck(cmdAck)
);

`default_nettype wire

/* dv/oramPathAddrTb.sv */
//==========================================================================
// ORAM path address testbench
// sends leaves over the four-phase port, answers commands with random
// delays and queues the expected bursts of every path for the checker
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module oramPathAddrTb;

	import oramGeomPkg::*;
	import dramMapPkg::*;

	localparam int pathLen = (oramL + 1) * burstsPerBkt; // 40 bursts per path
	localparam int numPaths = 62;  // 1 + 1 + 50 + 8 + 2
	localparam int stallCycles = 20;
	localparam int watchdogNs = numPaths * 40 * 8 * 40 + 20000; // slowest case plus margin

	typedef logic [pathLen-1:0][dramAddrW-1:0] addrListT;

	logic Clock, rstN;
	logic leafReq, leafAck, cmdReq, cmdLast, cmdAck;
	leafT leaf;
	dramAddrT cmdAddr;
	logic stallNext; // hold off the next command for stallCycles
	time stallEnd;   // when the stalled command got its ack
	time ackTime;    // when the last leaf was acknowledged

	tbClock clkGen (.Clock(Clock), .rstN(rstN));

	oramPathAddr i_dut (
		.Clock(Clock),
		.rstN(rstN),
		.leafReq(leafReq),
		.leaf(leaf),
		.leafAck(leafAck),
		.cmdReq(cmdReq),
		.cmdAddr(cmdAddr),
		.cmdLast(cmdLast),
		.cmdAck(cmdAck)
	);

	pathChecker chk (
		.Clock(Clock),
		.rstN(rstN),
		.cmdReq(cmdReq),
		.cmdAddr(cmdAddr),
		.cmdLast(cmdLast)
	);

	// expected bursts of one path: subtrees of lSt levels in 2^lSt slots,
	// the short bottom layer packed after all full subtrees
	function automatic addrListT pathAddrs(input leafT l);
		addrListT res;
		int st;   // heap index in the tree of subtrees
		int inSt; // heap index of the bucket inside its subtree
		int grp;  // branch bits taken inside the current subtree, first in the msb
		int bkt;
		st = 0;
		inSt = 0;
		grp = 0;
		for (int lv = 0; lv <= oramL; lv++) begin
			if (lStBottom != 0 && lv >= (numSt - 1) * lSt) begin
				bkt = numTallSt * (1 << lSt) + (st - numTallSt) * (1 << lStBottom) + inSt;
			end else begin
				bkt = st * (1 << lSt) + inSt;
			end
			for (int k = 0; k < burstsPerBkt; k++) begin
				res[lv * burstsPerBkt + k] = dramAddrW'(int'(dramBase) + bkt * burstsPerBkt + k);
			end
			if (lv < oramL) begin
				grp = grp * 2 + int'(l[lv]); // leaf lsb picks the branch at the root
				if (lv % lSt == lSt - 1) begin
					st = st * (1 << lSt) + 1 + grp;
					inSt = 0;
					grp = 0;
				end else begin
					inSt = inSt * 2 + 1 + int'(l[lv]);
				end
			end
		end
		return res;
	endfunction

	// expectations go in before the leaf, so order follows submission
	task automatic sendLeaf(input leafT l);
		chk.expectPath(pathAddrs(l));
		leafReq <= 1'b1;
		leaf <= l;
		do begin
			@(posedge Clock);
		end while (!leafAck);
		ackTime = $time;
		leafReq <= 1'b0;
		do begin
			@(posedge Clock);
		end while (leafAck); // returns on the edge where a new req may rise
	endtask

	task automatic drainPaths();
		while (chk.pending() != 0 || cmdReq || cmdAck) begin
			@(posedge Clock);
		end
	endtask

	// command side of the four-phase handshake
	initial begin : acknowledger
		int delay;
		logic stalled;
		cmdAck = 1'b0;
		forever begin
			@(posedge Clock);
			if (cmdReq && !cmdAck) begin
				stalled = stallNext;
				if (stalled) begin
					delay = stallCycles;
					stallNext <= 1'b0;
				end else begin
					delay = int'($urandom % 4); // 0 to 3 cycles
				end
				repeat (delay) @(posedge Clock);
				cmdAck <= 1'b1;
				if (stalled) begin
					stallEnd = $time;
				end
			end else if (!cmdReq && cmdAck) begin
				cmdAck <= 1'b0;
			end
		end
	end

	initial begin : stimulus
		void'($urandom(32'h7eea_b3f3));
		leafReq = 1'b0;
		leaf = '0;
		stallNext = 1'b0;
		stallEnd = 0;
		ackTime = 0;
		wait (rstN === 1'b1);
		@(posedge Clock);

		sendLeaf(leafT'(0));
		drainPaths();
		chk.finishTest("all-zero leaf");

		sendLeaf('1); // deepest subtrees, bottom slot formula
		drainPaths();
		chk.finishTest("all-ones leaf");

		for (int i = 0; i < 50; i++) begin
			repeat ($urandom % 4) @(posedge Clock);
			sendLeaf(leafT'($urandom));
		end
		drainPaths();
		chk.finishTest("random leaves");

		for (int i = 0; i < 8; i++) begin
			sendLeaf(leafT'(i * 61 + 7)); // req rises again as soon as ack falls
		end
		drainPaths();
		chk.finishTest("back-to-back leaves");

		stallNext <= 1'b1; // first burst of the next path waits 20 cycles
		sendLeaf(leafT'(9'h0a5));
		sendLeaf(leafT'(9'h15a));
		drainPaths();
		if (stallEnd == 0) begin
			chk.reportError("the long cmdAck stall never took place");
		end else if (ackTime <= stallEnd) begin
			chk.reportError("leafAck for the second leaf came before the stall cleared");
		end
		chk.finishTest("leaf during a stall");

		chk.closeReport();
		if (chk.errCount == 0 && i_dut.u_props.propFails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdogNs);
		$display("timed out after %0d ns with %0d bursts still expected", watchdogNs,
			chk.pending());
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* oramPathAddr.f */
hw/oramGeomPkg.sv
hw/dramMapPkg.sv
hw/pathAddrIf.sv
hw/pathGen.sv
hw/bktHeadGen.sv
hw/burstIssue.sv
hw/oramPathAddr.sv
dv/tbClock.sv
dv/pathChecker.sv
dv/pathAddr_properties.sv
dv/oramPathAddrTb.sv

/* runSim.sh */
#!/bin/sh
# compile the ORAM path address testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module oramPathAddrTb -f oramPathAddr.f \
	--Mdir obj_dir -o oramPathAddrSim

# the log decides the result, so a nonzero exit of the model is tolerated here
./obj_dir/oramPathAddrSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
if ! grep -q "All tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation clean"
